/* rtl/pet_pkg.sv */
package pet_pkg;

    typedef enum logic [1:0] {
        NEED_HEALTH = 2'd0,
        NEED_ENERGY = 2'd1,
        NEED_HUNGER = 2'd2,
        NEED_FUN    = 2'd3
    } need_e;

    typedef logic [3:0] level_t;

    localparam level_t LEVEL_MIN   = 4'd1;
    localparam level_t LEVEL_MAX   = 4'd10;
    localparam level_t LEVEL_RESET = 4'd8;
    localparam level_t HAPPY_LEVEL = 4'd5;   // Lowest level that still smiles

    typedef struct packed {
        level_t health;
        level_t energy;
        level_t hunger;
        level_t fun;
    } pet_levels_t;

    // Every bit means the player is asking for it
    typedef struct packed {
        logic health;
        logic food;
        logic play;
        logic sleep;
        logic test_req;
    } care_t;

    typedef struct packed {
        logic test;
        logic dead;
    } pet_mode_t;

    typedef struct packed {
        need_e need;
        logic  happy;
        logic  sleep;
        logic  dead;
    } face_t;

    // Segment order gfedcba, a zero lights the segment
    function automatic logic [6:0] seg_code(level_t level);
        case (level)
            4'd0:    return 7'b1000000;
            4'd1:    return 7'b1111001;
            4'd2:    return 7'b0100100;
            4'd3:    return 7'b0110000;
            4'd4:    return 7'b0011001;
            4'd5:    return 7'b0010010;
            4'd6:    return 7'b0000010;
            4'd7:    return 7'b1111000;
            4'd8:    return 7'b0000000;
            4'd9:    return 7'b0010000;
            4'd10:   return 7'b0001000;   // Letter A
            default: return 7'b1111111;
        endcase
    endfunction

endpackage

/* rtl/tick_divider.sv */
module tick_divider #(
    parameter int TICK_DIVISOR = 15_000_000
) (
    input  logic clk,
    input  logic btn_reset,
    output logic tick
);

    localparam int CNT_W = (TICK_DIVISOR > 1) ? $clog2(TICK_DIVISOR) : 1;

    logic [CNT_W-1:0] count;

    always_ff @(posedge clk) begin
        if (!btn_reset) begin
            count <= '0;
            tick  <= 1'b0;
        end else if (count == CNT_W'(TICK_DIVISOR - 1)) begin
            count <= '0;
            tick  <= 1'b1;   // Wrap cycle
        end else begin
            count <= count + CNT_W'(1);
            tick  <= 1'b0;
        end
    end

    // The pet clock is a strobe, never a level
    a_tick_single: assert property (@(posedge clk) disable iff (!btn_reset) tick |=> !tick);

endmodule

/* rtl/care_inputs.sv */
module care_inputs (
    input  logic           clk,
    input  logic           btn_reset,
    input  logic           btn_health,
    input  logic           btn_food,
    input  logic           play_sensor,
    input  logic           tilt,
    input  logic           btn_test,
    output pet_pkg::care_t care
);

    import pet_pkg::*;

    care_t raw;
    care_t sync_q;

    // Polarity fixed before the first flop
    always_comb begin
        raw.health   = !btn_health;
        raw.food     = !btn_food;
        raw.play     = play_sensor;
        raw.sleep    = !tilt;        // Pet lying down
        raw.test_req = !btn_test;
    end

    always_ff @(posedge clk) begin
        if (!btn_reset) begin
            sync_q <= '0;            // Nothing asked for
        end else begin
            sync_q <= raw;
        end
    end

    always_ff @(posedge clk) begin
        if (!btn_reset) begin
            care <= '0;
        end else begin
            care <= sync_q;          // Second stage
        end
    end

endmodule

/* rtl/pet_mode_regs.sv */
module pet_mode_regs (
    input  logic                 clk,
    input  logic                 btn_reset,
    input  logic                 tick,
    input  logic                 test_req,
    input  pet_pkg::pet_levels_t levels,
    output pet_pkg::pet_mode_t   mode
);

    import pet_pkg::*;

    logic all_min;

    assign all_min = (levels.health == LEVEL_MIN) && (levels.energy == LEVEL_MIN) &&
                     (levels.hunger == LEVEL_MIN) && (levels.fun == LEVEL_MIN);

    always_ff @(posedge clk) begin
        if (!btn_reset) begin
            mode <= '0;
        end else if (tick) begin
            mode.test <= mode.test | test_req;   // Sticky until reset
            if (mode.test || test_req) begin
                mode.dead <= 1'b0;               // Test mode revives the pet
            end else if (all_min) begin
                mode.dead <= 1'b1;
            end
        end
    end

    // The needs core would see conflicting orders otherwise
    a_mode_exclusive: assert property (
        @(posedge clk) disable iff (!btn_reset) !(mode.test && mode.dead)
    );

endmodule

/* rtl/pet_needs.sv */
module pet_needs #(
    parameter int CARE_TICKS  = 3,
    parameter int DECAY_TICKS = 25
) (
    input  logic                 clk,
    input  logic                 btn_reset,
    input  logic                 tick,
    input  pet_pkg::care_t       care,
    input  pet_pkg::pet_mode_t   mode,
    output pet_pkg::pet_levels_t levels,
    output pet_pkg::need_e       selected
);

    import pet_pkg::*;

    localparam int CW = (CARE_TICKS > 1) ? $clog2(CARE_TICKS) : 1;
    localparam int DW = (DECAY_TICKS > 1) ? $clog2(DECAY_TICKS) : 1;

    level_t        lvl_q   [4];
    logic [DW-1:0] timer_q [4];
    logic [CW-1:0] hold_q  [4];
    logic          test_seen;   // Test flag as of the last tick
    logic          test_entry;
    logic [3:0]    req;
    logic [3:0]    care_done;
    need_e         next_sel;

    // Care requests indexed by the need they feed
    assign req[NEED_HEALTH] = care.health;
    assign req[NEED_ENERGY] = care.sleep;
    assign req[NEED_HUNGER] = care.food;
    assign req[NEED_FUN]    = care.play;

    assign test_entry = mode.test && !test_seen;

    always_comb begin
        for (int i = 0; i < 4; i++) begin
            care_done[i] = req[i] && !mode.dead && (hold_q[i] == CW'(CARE_TICKS - 1));
        end
    end

    always_comb begin
        if (care.health) begin
            next_sel = NEED_HEALTH;
        end else if (care.food) begin
            next_sel = NEED_HUNGER;
        end else if (care.play) begin
            next_sel = NEED_FUN;
        end else begin
            next_sel = NEED_ENERGY;
        end
    end

    always_ff @(posedge clk) begin
        if (!btn_reset) begin
            for (int i = 0; i < 4; i++) begin
                lvl_q[i]   <= LEVEL_RESET;
                timer_q[i] <= '0;
                hold_q[i]  <= '0;
            end
            test_seen <= 1'b0;
            selected  <= NEED_HEALTH;
        end else if (tick) begin
            test_seen <= mode.test;
            if (!mode.dead && (|req)) begin
                selected <= next_sel;
            end
            for (int i = 0; i < 4; i++) begin
                if (test_entry) begin
                    lvl_q[i]   <= LEVEL_MIN;   // All needs start empty in test mode
                    timer_q[i] <= '0;
                    hold_q[i]  <= '0;
                end else begin
                    if (req[i] && !mode.dead && !care_done[i]) begin
                        hold_q[i] <= hold_q[i] + CW'(1);
                    end else begin
                        hold_q[i] <= '0;
                    end

                    if (care_done[i]) begin
                        if (mode.test) begin
                            lvl_q[i] <= (lvl_q[i] == LEVEL_MIN) ? LEVEL_MAX : LEVEL_MIN;
                        end else begin
                            if (lvl_q[i] < LEVEL_MAX) begin
                                lvl_q[i] <= lvl_q[i] + 4'd1;
                            end
                            timer_q[i] <= '0;  // Fresh care restarts decay
                        end
                    end else if (!mode.test && !mode.dead) begin
                        if (lvl_q[i] == LEVEL_MIN) begin
                            timer_q[i] <= '0;
                        end else if (timer_q[i] == DW'(DECAY_TICKS - 1)) begin
                            timer_q[i] <= '0;
                            lvl_q[i]   <= lvl_q[i] - 4'd1;
                        end else begin
                            timer_q[i] <= timer_q[i] + DW'(1);
                        end
                    end
                end
            end
        end
    end

    assign levels = '{health: lvl_q[NEED_HEALTH], energy: lvl_q[NEED_ENERGY],
                      hunger: lvl_q[NEED_HUNGER], fun: lvl_q[NEED_FUN]};

    function automatic logic in_range(level_t level);
        return (level >= LEVEL_MIN) && (level <= LEVEL_MAX);
    endfunction

    a_levels_range: assert property (
        @(posedge clk) disable iff (!btn_reset)
        in_range(levels.health) && in_range(levels.energy) &&
        in_range(levels.hunger) && in_range(levels.fun)
    );

endmodule

/* rtl/pet_display.sv */
module pet_display (
    input  logic                 clk,
    input  logic                 btn_reset,
    input  pet_pkg::pet_levels_t levels,
    input  pet_pkg::need_e       selected,
    input  pet_pkg::pet_mode_t   mode,
    input  logic                 sleep,
    output pet_pkg::face_t       face,
    output logic [6:0]           seg_display,
    output logic                 test_led
);

    import pet_pkg::*;

    level_t sel_level;

    always_comb begin
        case (selected)
            NEED_HEALTH: sel_level = levels.health;
            NEED_ENERGY: sel_level = levels.energy;
            NEED_HUNGER: sel_level = levels.hunger;
            default:     sel_level = levels.fun;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!btn_reset) begin
            // Matches the face for the reset levels
            face.need   <= NEED_HEALTH;
            face.happy  <= (LEVEL_RESET >= HAPPY_LEVEL);
            face.sleep  <= 1'b0;
            face.dead   <= 1'b0;
            seg_display <= seg_code(LEVEL_RESET);
            test_led    <= 1'b1;
        end else begin
            face.need   <= selected;
            face.happy  <= !mode.dead && (sel_level >= HAPPY_LEVEL);
            face.sleep  <= !mode.dead && sleep;   // Dead face wins
            face.dead   <= mode.dead;
            seg_display <= seg_code(sel_level);
            test_led    <= !mode.test;            // LED is active low
        end
    end

endmodule

/* rtl/pet_top.sv */
module pet_top #(
    parameter int TICK_DIVISOR = 15_000_000,
    parameter int CARE_TICKS   = 3,
    parameter int DECAY_TICKS  = 25
) (
    input  logic           clk,
    input  logic           btn_reset,
    input  logic           btn_health,
    input  logic           btn_food,
    input  logic           play_sensor,
    input  logic           tilt,
    input  logic           btn_test,
    output pet_pkg::face_t face,
    output logic [6:0]     seg_display,
    output logic           test_led
);

    import pet_pkg::*;

    logic        tick;
    care_t       care;
    pet_mode_t   mode;
    pet_levels_t levels;
    need_e       selected;

    tick_divider #(.TICK_DIVISOR(TICK_DIVISOR)) i_tick (
        .clk, .btn_reset, .tick
    );

    care_inputs i_care (
        .clk, .btn_reset, .btn_health, .btn_food, .play_sensor, .tilt, .btn_test, .care
    );

    pet_mode_regs i_mode (
        .clk, .btn_reset, .tick, .test_req(care.test_req), .levels, .mode
    );

    pet_needs #(
        .CARE_TICKS (CARE_TICKS),
        .DECAY_TICKS(DECAY_TICKS)
    ) i_needs (
        .clk, .btn_reset, .tick, .care, .mode, .levels, .selected
    );

    pet_display i_display (
        .clk, .btn_reset, .levels, .selected, .mode, .sleep(care.sleep),
        .face, .seg_display, .test_led
    );

endmodule

/* verification/pet_tb_table.svh */
typedef struct packed {
    logic [4:0] pins;
    logic [7:0] ticks;
} step_t;

localparam int NUM_STEPS = 24;

// Pins are btn_health, btn_food, play_sensor, tilt, btn_test; ticks 0 picks a random hold
localparam step_t STEPS [NUM_STEPS] = '{
    '{5'b01011, 8'd3},    // Health care once
    '{5'b01011, 8'd9},    // Health up to the cap
    '{5'b11011, 8'd1},
    '{5'b10011, 8'd3},    // Food
    '{5'b10011, 8'd6},
    '{5'b11111, 8'd3},    // Play
    '{5'b11011, 8'd1},
    '{5'b11111, 8'd0},    // Play of random length
    '{5'b11001, 8'd6},    // Lying down
    '{5'b11011, 8'd8},    // Decay from here on
    '{5'b11011, 8'd8},
    '{5'b11011, 8'd16},
    '{5'b11011, 8'd16},
    '{5'b11011, 8'd16},
    '{5'b11011, 8'd24},   // All needs empty, pet dies
    '{5'b01011, 8'd6},    // Care while dead
    '{5'b11001, 8'd4},    // Shown need cared for while dead
    '{5'b11010, 8'd2},    // Enter test mode
    '{5'b01011, 8'd3},    // Toggle health
    '{5'b01011, 8'd3},
    '{5'b11011, 8'd16},   // No decay in test mode
    '{5'b10011, 8'd3},
    '{5'b11001, 8'd3},    // Energy to the cap
    '{5'b11011, 8'd8}     // Full level holds
};

/* verification/pet_tb.sv */
module pet_tb;

    import pet_pkg::*;

    localparam int TICK_DIVISOR   = 4;
    localparam int CARE_TICKS     = 3;
    localparam int DECAY_TICKS    = 8;
    localparam int CLK_PERIOD     = 40;
    localparam int DRIVE_DELAY    = 5;
    localparam int RAND_MAX_TICKS = 6;

    `include "pet_tb_table.svh"

    logic       clk;
    logic       btn_reset;
    logic       btn_health;
    logic       btn_food;
    logic       play_sensor;
    logic       tilt;
    logic       btn_test;
    face_t      face;
    logic [6:0] seg_display;
    logic       test_led;

    int     edges;            // Rising edges since reset release
    int     errors;
    level_t m_lvl   [4];      // Reference model state
    int     m_timer [4];
    int     m_hold  [4];
    logic   m_test;
    logic   m_test_prev;
    logic   m_dead;
    need_e  m_sel;

    pet_top #(
        .TICK_DIVISOR(TICK_DIVISOR),
        .CARE_TICKS  (CARE_TICKS),
        .DECAY_TICKS (DECAY_TICKS)
    ) i_dut (
        .clk, .btn_reset, .btn_health, .btn_food, .play_sensor, .tilt, .btn_test,
        .face, .seg_display, .test_led
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic next_edge();
        @(posedge clk);
        edges++;
    endtask

    // The needs core acts on edges D+1, 2D+1 and so on
    task automatic wait_tick();
        do begin
            next_edge();
        end while ((edges <= TICK_DIVISOR) || ((edges - 1) % TICK_DIVISOR != 0));
    endtask

    task automatic apply_tick(input logic [4:0] pins);
        logic [3:0] req;
        logic       test_req;
        logic       entering;
        logic       all_min;
        logic       done;
        req[NEED_HEALTH] = !pins[4];
        req[NEED_HUNGER] = !pins[3];
        req[NEED_FUN]    = pins[2];
        req[NEED_ENERGY] = !pins[1];
        test_req = !pins[0];
        entering = m_test && !m_test_prev;    // Test flag seen for the first time
        all_min  = 1'b1;
        for (int i = 0; i < 4; i++) begin
            all_min &= (m_lvl[i] == LEVEL_MIN);
        end
        if (!m_dead && (req != 4'b0)) begin
            if (req[NEED_HEALTH])
                m_sel = NEED_HEALTH;
            else if (req[NEED_HUNGER])
                m_sel = NEED_HUNGER;
            else if (req[NEED_FUN])
                m_sel = NEED_FUN;
            else
                m_sel = NEED_ENERGY;
        end
        for (int i = 0; i < 4; i++) begin
            done = 1'b0;
            if (entering) begin
                m_lvl[i]   = LEVEL_MIN;
                m_timer[i] = 0;
                m_hold[i]  = 0;
            end else if (m_dead || !req[i]) begin
                m_hold[i] = 0;
            end else if (m_hold[i] == CARE_TICKS - 1) begin
                done      = 1'b1;
                m_hold[i] = 0;
                if (m_test) begin
                    m_lvl[i] = (m_lvl[i] == LEVEL_MIN) ? LEVEL_MAX : LEVEL_MIN;
                end else begin
                    if (m_lvl[i] < LEVEL_MAX)
                        m_lvl[i]++;
                    m_timer[i] = 0;
                end
            end else begin
                m_hold[i]++;
            end
            if (!entering && !done && !m_test && !m_dead) begin
                if (m_lvl[i] == LEVEL_MIN) begin
                    m_timer[i] = 0;
                end else begin
                    m_timer[i]++;
                    if (m_timer[i] == DECAY_TICKS) begin
                        m_timer[i] = 0;
                        m_lvl[i]--;
                    end
                end
            end
        end
        m_test_prev = m_test;
        if (m_test || test_req)
            m_dead = 1'b0;
        else if (all_min)
            m_dead = 1'b1;
        m_test = m_test || test_req;
    endtask

    task automatic compare(input string name, input logic [31:0] got,
                           input logic [31:0] expected);
        if (got !== expected) begin
            errors++;
            $display("[FAIL] t=%0t %s got %0h expected %0h", $time, name, got, expected);
            $display("FAIL: see errors above");
            $fatal(1, "stopping at the first mismatch");
        end
    endtask

    task automatic check_outputs();
        level_t shown;
        shown = m_lvl[m_sel];
        compare("face.need", face.need, m_sel);
        compare("face.happy", face.happy, !m_dead && (shown >= HAPPY_LEVEL));
        compare("face.sleep", face.sleep, !m_dead && !tilt);
        compare("face.dead", face.dead, m_dead);
        compare("seg_display", seg_display, seg_code(shown));
        compare("test_led", test_led, !m_test);
    endtask

    initial begin
        step_t step;
        int    n;
        btn_reset = 1'b0;
        {btn_health, btn_food, play_sensor, tilt, btn_test} = 5'b11011;   // Idle pins
        errors = 0;
        edges  = 0;
        void'($urandom(32'h4ecc));
        for (int i = 0; i < 4; i++) begin
            m_lvl[i]   = LEVEL_RESET;
            m_timer[i] = 0;
            m_hold[i]  = 0;
        end
        m_test      = 1'b0;
        m_test_prev = 1'b0;
        m_dead      = 1'b0;
        m_sel       = NEED_HEALTH;
        repeat (16) @(posedge clk);
        #DRIVE_DELAY btn_reset = 1'b1;
        next_edge();
        #DRIVE_DELAY check_outputs();     // Reset state
        for (int s = 0; s < NUM_STEPS; s++) begin
            step = STEPS[s];
            n = (step.ticks == 0) ? 1 + int'($urandom % RAND_MAX_TICKS) : int'(step.ticks);
            {btn_health, btn_food, play_sensor, tilt, btn_test} = step.pins;
            repeat (n) begin
                wait_tick();
                apply_tick(step.pins);
            end
            next_edge();                  // Display registers one cycle later
            #DRIVE_DELAY check_outputs();
        end
        if (errors == 0)
            $display("PASS: all tests");
        else
            $display("FAIL: see errors above");
        $finish;
    end

    initial begin
        longint limit;
        limit = 16 + 8 * NUM_STEPS;       // Margin in cycles
        for (int s = 0; s < NUM_STEPS; s++) begin
            limit += TICK_DIVISOR * ((STEPS[s].ticks == 0) ? RAND_MAX_TICKS : STEPS[s].ticks);
        end
        #(limit * CLK_PERIOD);
        $display("Timeout: the step table did not finish within %0d time units",
                 limit * CLK_PERIOD);
        $display("FAIL: see errors above");
        $fatal(1, "watchdog expired");
    end

endmodule

/* project.f */
+incdir+verification
rtl/pet_pkg.sv
rtl/tick_divider.sv
rtl/care_inputs.sv
rtl/pet_mode_regs.sv
rtl/pet_needs.sv
rtl/pet_display.sv
rtl/pet_top.sv
verification/pet_tb.sv
